/* Bender.yml */
package:
  name: modelCore

sources:
  - isaPkg.sv
  - pipePkg.sv
  - regFile.sv
  - instrDecode.sv
  - forwardUnit.sv
  - alu.sv
  - execute.sv
  - retireStage.sv
  - modelCore.sv
  - target: simulation
    files:
      - modelCore_tb.sv

/* alu.sv */
// Combinational 16-bit ALU
// Produces the result and all three flag candidates for every opcode
`timescale 1ns/1ps

module alu (
  input  isaPkg::wordT   aluIn1,
  input  isaPkg::wordT   aluIn2,
  input  isaPkg::opcodeE op,
  output isaPkg::wordT   aluOut,
  output logic           zSet,
  output logic           nSet,
  output logic           vSet
);
  import isaPkg::*;

  opcodeE     aluOp;   // I-type folded onto R-type
  wordT       sum;
  wordT       diff;
  logic [3:0] shAmt;   // Low nibble of second operand

  assign sum   = aluIn1 + aluIn2;  // Wraps
  assign diff  = aluIn1 - aluIn2;
  assign shAmt = aluIn2[3:0];

  always_comb begin
    case (op)
      ADDI:    aluOp = ADD;
      ANDI:    aluOp = AND;
      ORI:     aluOp = OR;
      default: aluOp = op;
    endcase
  end

  always_comb begin
    vSet = 1'b0;
    case (aluOp)
      ADD: begin
        aluOut = sum;
        vSet   = (aluIn1[15] == aluIn2[15]) && (sum[15] != aluIn1[15]);  // Like signs
      end
      SUB: begin
        aluOut = diff;
        vSet   = (aluIn1[15] != aluIn2[15]) && (diff[15] != aluIn1[15]);  // Unlike signs
      end
      AND:     aluOut = aluIn1 & aluIn2;
      OR:      aluOut = aluIn1 | aluIn2;
      XOR:     aluOut = aluIn1 ^ aluIn2;
      SLL:     aluOut = aluIn1 << shAmt;
      SRL:     aluOut = aluIn1 >> shAmt;
      SRA:     aluOut = wordT'($signed(aluIn1) >>> shAmt);  // Sign fill
      LUI:     aluOut = aluIn2;  // Immediate already in upper byte
      default: aluOut = '0;      // NOP codes
    endcase
  end

  assign zSet = (aluOut == '0);
  assign nSet = aluOut[15];

endmodule

/* execute.sv */
// Execute stage of the model core
// Forwarded operand select, ALU and the Z, N, V flag registers
`timescale 1ns/1ps

module execute (
  input  logic          clk,
  input  logic          rst,
  input  pipePkg::idExT idEx,
  input  isaPkg::wordT  exMemResult,
  input  isaPkg::wordT  memWbResult,
  input  logic [1:0]    fwdA,
  input  logic [1:0]    fwdB,
  output pipePkg::exWbT exOut,
  output isaPkg::flagsT flags
);
  import isaPkg::*;

  wordT aluIn1;   // First operand after forwarding
  wordT rtValue;  // Second register operand after forwarding
  wordT aluIn2;   // Second operand after immediate select
  wordT aluOut;
  logic zSet, nSet, vSet;

  ////////////////////
  // Operand select
  ////////////////////
  assign aluIn1 = (fwdA == 2'd2) ? exMemResult :
                  (fwdA == 2'd1) ? memWbResult : idEx.rsData;
  assign rtValue = (fwdB == 2'd2) ? exMemResult :
                   (fwdB == 2'd1) ? memWbResult : idEx.rtData;
  assign aluIn2 = idEx.aluSrc ? idEx.imm : rtValue;

  alu iAlu (
    .aluIn1 (aluIn1),
    .aluIn2 (aluIn2),
    .op     (idEx.op),
    .aluOut (aluOut),
    .zSet   (zSet),
    .nSet   (nSet),
    .vSet   (vSet)
  );

  assign exOut = '{valid: idEx.valid, wbEn: idEx.wbEn, rd: idEx.rd, result: aluOut};

  ////////////////////
  // Flags
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else if (idEx.valid) begin  // Bubbles leave flags alone
      if (idEx.zEn) flags.z <= zSet;
      if (idEx.nvEn) begin
        flags.n <= nSet;
        flags.v <= vSet;
      end
    end
  end

endmodule

/* forwardUnit.sv */
// Forwarding control for the execute stage
// Matches both sources against EX/MEM and MEM/WB, newest record wins
`timescale 1ns/1ps

module forwardUnit (
  input  pipePkg::idExT idEx,
  input  pipePkg::exWbT exMem,
  input  pipePkg::exWbT memWb,
  output logic [1:0]    fwdA,
  output logic [1:0]    fwdB
);
  import isaPkg::*;
  import pipePkg::*;

  // 2 from EX/MEM, 1 from MEM/WB, 0 keeps the register file value
  function automatic logic [1:0] pickSource(regIdxT src, exWbT newer, exWbT older);
    logic [1:0] sel;
    sel = 2'd0;
    if (src != '0) begin  // r0 is constant
      if (newer.valid && newer.wbEn && (newer.rd == src)) begin
        sel = 2'd2;
      end else if (older.valid && older.wbEn && (older.rd == src)) begin
        sel = 2'd1;
      end
    end
    return sel;
  endfunction

  assign fwdA = pickSource(idEx.rs, exMem, memWb);
  assign fwdB = pickSource(idEx.rt, exMem, memWb);

endmodule

/* instrDecode.sv */
// Decode stage of the model core
// Picks the instruction layout, reads operands and registers the ID/EX record
`timescale 1ns/1ps

module instrDecode (
  input  logic           clk,
  input  logic           rst,
  input  logic           instrValid,
  input  isaPkg::instrU  instr,
  output isaPkg::regIdxT rsAddr,
  output isaPkg::regIdxT rtAddr,
  input  isaPkg::wordT   rsData,
  input  isaPkg::wordT   rtData,
  output pipePkg::idExT  idEx
);
  import isaPkg::*;
  import pipePkg::*;

  opcodeE     op;        // Same bits in both views
  logic       isImm;     // I-type layout
  logic [7:0] imm8;
  idExT       nextIdEx;  // Record loaded into ID/EX

  assign op    = instr.rType.opcode;
  assign isImm = isIType(op);
  assign imm8  = instr.iType.imm8;

  ////////////////////
  // Register reads
  ////////////////////
  assign rsAddr = isImm ? instr.iType.rd : instr.rType.rs;  // I-type sources its own rd
  assign rtAddr = isImm ? '0 : instr.rType.rt;               // r0 never forwards

  always_comb begin
    nextIdEx.valid  = instrValid && !isNop(op);  // Invalid or NOP gives a bubble
    nextIdEx.op     = op;
    nextIdEx.rd     = instr.rType.rd;  // rd sits at the same bits in both views
    nextIdEx.rs     = rsAddr;
    nextIdEx.rt     = rtAddr;
    nextIdEx.rsData = rsData;
    nextIdEx.rtData = rtData;
    nextIdEx.aluSrc = isImm;
    nextIdEx.zEn    = updatesZ(op);
    nextIdEx.nvEn   = updatesNV(op);
    nextIdEx.wbEn   = !isNop(op);
    case (op)
      ADDI:    nextIdEx.imm = {{8{imm8[7]}}, imm8};  // Sign extend
      LUI:     nextIdEx.imm = {imm8, 8'h00};         // Upper byte
      default: nextIdEx.imm = {8'h00, imm8};         // Zero extend for ANDI, ORI
    endcase
  end

  ////////////////////
  // ID/EX register
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      idEx.valid <= 1'b0;
    end else begin
      idEx <= nextIdEx;
    end
  end

endmodule

/* isaPkg.sv */
// Instruction set of the 16-bit model CPU
// Opcodes, the two instruction layouts, flags and per-opcode flag rules
package isaPkg;

  typedef logic [3:0]  regIdxT;  // Register index, r0 reads as zero
  typedef logic [15:0] wordT;    // Data word

  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    AND  = 4'd2,
    OR   = 4'd3,
    XOR  = 4'd4,
    SLL  = 4'd5,
    SRL  = 4'd6,
    SRA  = 4'd7,
    ADDI = 4'd8,   // rd <= rd + sext(imm8)
    ANDI = 4'd9,   // rd <= rd & zext(imm8)
    ORI  = 4'd10,  // rd <= rd | zext(imm8)
    LUI  = 4'd11,  // rd <= {imm8, 8'h00}
    NOP  = 4'd15   // Codes 12 to 14 behave the same
  } opcodeE;

  typedef struct packed {
    opcodeE opcode;
    regIdxT rd;  // Destination
    regIdxT rs;  // First source
    regIdxT rt;  // Second source or shift amount
  } rTypeT;

  // I-type has no source field, rd is read and written
  typedef struct packed {
    opcodeE     opcode;
    regIdxT     rd;
    logic [7:0] imm8;
  } iTypeT;

  typedef union packed {
    rTypeT rType;
    iTypeT iType;
  } instrU;

  typedef struct packed {
    logic z;  // Zero
    logic n;  // Negative
    logic v;  // Signed overflow
  } flagsT;

  function automatic logic isNop(opcodeE op);
    return op > LUI;  // 12 to 15
  endfunction

  function automatic logic isIType(opcodeE op);
    return op inside {ADDI, ANDI, ORI, LUI};
  endfunction

  function automatic logic updatesZ(opcodeE op);
    return !isNop(op) && (op != LUI);  // Every ALU op except LUI
  endfunction

  function automatic logic updatesNV(opcodeE op);
    return op inside {ADD, SUB, ADDI};  // Arithmetic only
  endfunction

endpackage

/* modelCore.f */
isaPkg.sv
pipePkg.sv
regFile.sv
instrDecode.sv
forwardUnit.sv
alu.sv
execute.sv
retireStage.sv
modelCore.sv
modelCore_tb.sv

/* modelCore.sv */
// Top level of the 16-bit model core
// Decode, execute and two retire registers with full forwarding
`timescale 1ns/1ps

module modelCore (
  input  logic           clk,
  input  logic           rst,
  input  logic           instrValid,
  input  isaPkg::instrU  instr,
  output logic           wbValid,
  output isaPkg::regIdxT wbReg,
  output isaPkg::wordT   wbData,
  output isaPkg::flagsT  flags
);
  import isaPkg::*;
  import pipePkg::*;

  regIdxT     rsAddr, rtAddr;  // Decode read addresses
  wordT       rsData, rtData;
  idExT       idEx;
  exWbT       exOut, exMem, memWb;
  logic [1:0] fwdA, fwdB;

  assign wbValid = memWb.valid && memWb.wbEn;  // Also the register file write enable
  assign wbReg   = memWb.rd;
  assign wbData  = memWb.result;

  regFile iRegFile (
    .clk(clk), .rst(rst),
    .rdAddrA(rsAddr), .rdAddrB(rtAddr),
    .rdDataA(rsData), .rdDataB(rtData),
    .wrEn(wbValid), .wrAddr(wbReg), .wrData(wbData)
  );

  instrDecode iDecode (
    .clk(clk), .rst(rst), .instrValid(instrValid), .instr(instr),
    .rsAddr(rsAddr), .rtAddr(rtAddr), .rsData(rsData), .rtData(rtData), .idEx(idEx)
  );

  forwardUnit iForward (.idEx(idEx), .exMem(exMem), .memWb(memWb), .fwdA(fwdA), .fwdB(fwdB));

  execute iExecute (
    .clk(clk), .rst(rst), .idEx(idEx),
    .exMemResult(exMem.result), .memWbResult(memWb.result),
    .fwdA(fwdA), .fwdB(fwdB), .exOut(exOut), .flags(flags)
  );

  retireStage iRetire (.clk(clk), .rst(rst), .exOut(exOut), .exMem(exMem), .memWb(memWb));

endmodule

/* modelCore_input.txt */
// Columns: valid instr wbExpected wbReg wbData flags, all hex
// flags is {z, n, v}, the state after the instruction executes
1 8105 1 1 0005 0 // ADDI r1, 05
1 82FD 1 2 FFFD 2 // ADDI r2, FD sign extended
1 0312 1 3 0002 0 // ADD r3, r1, r2
1 1431 1 4 FFFD 2 // SUB r4, r3, r1
1 B57F 1 5 7F00 2 // LUI r5, 7F
1 A5FF 1 5 7FFF 2 // ORI r5, FF zero extended
1 0655 1 6 FFFE 3 // ADD r6, r5, r5 overflow
1 9580 1 5 0080 3 // ANDI r5, 80 zero extended
1 1746 1 7 FFFF 2 // SUB r7, r4, r6
1 B880 1 8 8000 2 // LUI r8, 80
1 1981 1 9 7FFB 1 // SUB r9, r8, r1 overflow
1 7A83 1 A E000 1 // SRA r10, r8, r3 sign fill
1 6BA1 1 B 0700 1 // SRL r11, r10, r1
1 5CB6 1 C 0000 5 // SLL r12, r11, r6 amount 14
1 5D13 1 D 0014 1 // SLL r13, r1, r3
1 4E55 1 E 0000 5 // XOR r14, r5, r5
1 B112 1 1 1200 5 // LUI r1, 12 flags kept
1 F000 0 0 0000 5 // NOP
0 8201 0 0 0000 5 // Invalid cycle
1 C345 0 0 0000 5 // Code 12 acts as NOP
1 8033 1 0 0033 0 // ADDI r0, 33
1 0F01 1 F 1200 0 // ADD r15, r0, r1
1 22F9 1 2 1200 0 // AND r2, r15, r9
1 4492 1 4 6DFB 0 // XOR r4, r9, r2
1 338F 1 3 9200 0 // OR r3, r8, r15
1 0100 1 1 0000 4 // ADD r1, r0, r0

/* modelCore_tb.sv */
// Testbench for the model core
// Replays the instruction stream from the data file, checks write-back and flags
`timescale 1ns/1ps

module modelCore_tb;
  import isaPkg::*;

  localparam int maxRecords = 64;
  localparam int numFields  = 6;  // valid, instr, wbExpected, wbReg, wbData, flags

  logic   clk;
  logic   rst;
  logic   instrValid;
  instrU  instr;
  logic   wbValid;
  regIdxT wbReg;
  wordT   wbData;
  flagsT  flags;

  logic [15:0] stim [maxRecords*numFields];  // Records laid out field by field
  int          numRecords;
  int          errors;
  logic        loaded;

  modelCore i_dut (
    .clk        (clk),
    .rst        (rst),
    .instrValid (instrValid),
    .instr      (instr),
    .wbValid    (wbValid),
    .wbReg      (wbReg),
    .wbData     (wbData),
    .flags      (flags)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;  // 10 ns period

  function automatic logic [15:0] field(int rec, int idx);
    return stim[rec*numFields + idx];
  endfunction

  task automatic reportMismatch(input string test, input logic [15:0] expected,
                                input logic [15:0] actual);
    errors++;
    $display("[FAIL] %s expected %h actual %h", test, expected, actual);
  endtask

  ////////////////////
  // Stimulus and checks
  ////////////////////
  initial begin
    int          rec;
    logic [15:0] validWord;  // Valid column of the record being driven
    logic [15:0] expWb;
    logic [15:0] expReg;
    logic [15:0] expData;
    logic [15:0] expFlags;
    rst        = 1'b1;
    instrValid = 1'b1;
    instr      = 16'h817F;  // ADDI during reset, must be dropped
    errors     = 0;
    numRecords = 0;
    loaded     = 1'b0;
    for (int i = 0; i < maxRecords*numFields; i++) begin
      stim[i] = 16'hFFFF;  // End marker in the valid column
    end
    $readmemh("modelCore_input.txt", stim);
    while ((numRecords < maxRecords) && (field(numRecords, 0) != 16'hFFFF)) begin
      numRecords++;
    end
    loaded = 1'b1;
    if (numRecords == 0) begin
      errors++;
      $display("No stimulus records could be read from the data file");
    end
    repeat (10) begin  // Ten reset edges
      @(negedge clk);
      if (wbValid !== 1'b0) reportMismatch("reset wbValid", 16'h0, wbValid);
      if (flags !== 3'b000) reportMismatch("reset flags", 16'h0, flags);
    end
    rst = 1'b0;
    for (int k = 0; k < numRecords + 3; k++) begin
      if (k >= 3) begin  // Write-back slot of record k-3
        rec     = k - 3;
        expWb   = field(rec, 2);
        expReg  = field(rec, 3);
        expData = field(rec, 4);
        if (wbValid !== expWb[0])
          reportMismatch($sformatf("rec%0d wbValid", rec), expWb, wbValid);
        if (expWb[0] && (wbReg !== expReg[3:0]))
          reportMismatch($sformatf("rec%0d wbReg", rec), expReg, wbReg);
        if (expWb[0] && (wbData !== expData))
          reportMismatch($sformatf("rec%0d wbData", rec), expData, wbData);
      end else if (wbValid !== 1'b0) begin
        reportMismatch("after reset wbValid", 16'h0, wbValid);
      end
      if (k < 2) begin
        if (flags !== 3'b000) reportMismatch("after reset flags", 16'h0, flags);
      end else if (k - 2 < numRecords) begin  // Flags of record k-2
        rec      = k - 2;
        expFlags = field(rec, 5);
        if (flags !== expFlags[2:0])
          reportMismatch($sformatf("rec%0d flags", rec), expFlags, flags);
      end
      if (k < numRecords) begin
        validWord  = field(k, 0);
        instrValid = validWord[0];
        instr      = field(k, 1);
      end else begin
        instrValid = 1'b0;  // Drain
        instr      = 16'hF000;
      end
      @(negedge clk);
    end
    $display("Run complete with %0d errors over %0d records", errors, numRecords);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  ////////////////////
  // Watchdog
  ////////////////////
  initial begin
    wait (loaded);
    #((numRecords + 20) * 10);  // Reset, stream and drain fit well inside
    $display("Timeout: the run did not finish within the expected time");
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

/* pipePkg.sv */
// Stage records passed between the pipeline modules
// ID/EX carries decoded operands, EX/WB carries a result toward write-back
package pipePkg;
  import isaPkg::*;

  typedef struct packed {
    logic   valid;   // Real instruction, bubbles are 0
    opcodeE op;
    regIdxT rd;
    regIdxT rs;      // Source indices for forwarding
    regIdxT rt;
    wordT   rsData;  // Register file values read in decode
    wordT   rtData;
    wordT   imm;     // Already extended
    logic   aluSrc;  // 1 selects imm as second operand
    logic   zEn;     // Z update enable
    logic   nvEn;    // N and V update enable
    logic   wbEn;    // Writes rd
  } idExT;

  typedef struct packed {
    logic   valid;
    logic   wbEn;
    regIdxT rd;
    wordT   result;
  } exWbT;

endpackage

/* regFile.sv */
// Sixteen-entry register file with r0 tied to zero
// Two read ports, one write port, same-cycle writes bypass to the reads
`timescale 1ns/1ps

module regFile (
  input  logic           clk,
  input  logic           rst,
  input  isaPkg::regIdxT rdAddrA,
  input  isaPkg::regIdxT rdAddrB,
  output isaPkg::wordT   rdDataA,
  output isaPkg::wordT   rdDataB,
  input  logic           wrEn,
  input  isaPkg::regIdxT wrAddr,
  input  isaPkg::wordT   wrData
);
  import isaPkg::*;

  wordT regs [16];  // Storage, entry 0 never written

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && (wrAddr != '0)) begin
      regs[wrAddr] <= wrData;
    end
  end

  // r0 first, then write-through, then storage
  assign rdDataA = (rdAddrA == '0) ? '0 :
                   (wrEn && (wrAddr == rdAddrA)) ? wrData : regs[rdAddrA];
  assign rdDataB = (rdAddrB == '0) ? '0 :
                   (wrEn && (wrAddr == rdAddrB)) ? wrData : regs[rdAddrB];

endmodule

/* retireStage.sv */
// Retire registers of the model core
// EX/MEM then MEM/WB, both feed forwarding and MEM/WB drives write-back
`timescale 1ns/1ps

module retireStage (
  input  logic          clk,
  input  logic          rst,
  input  pipePkg::exWbT exOut,
  output pipePkg::exWbT exMem,
  output pipePkg::exWbT memWb
);

  ////////////////////
  // EX/MEM
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      exMem.valid <= 1'b0;  // Only control clears
    end else begin
      exMem <= exOut;       // Result straight from execute
    end
  end

  ////////////////////
  // MEM/WB
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      memWb.valid <= 1'b0;
    end else begin
      memWb <= exMem;       // No memory access, plain copy
    end
  end

endmodule
